// ==== l2_tlb.f ====
+incdir+source
source/l2_tlb_pkg.sv
source/l2_tlb_entry_array.sv
source/l2_tlb_replacement_unit.sv
source/l2_tlb.sv
dv/tb_l2_tlb_checker.sv
dv/tb_l2_tlb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the L2 TLB testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  -f l2_tlb.f \
  --top-module tb_l2_tlb \
  -o sim_l2_tlb

./obj_dir/sim_l2_tlb | tee sim.log

# Result is taken from the log
if grep -q "^NO ERRORS$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// ==== dv/tb_l2_tlb.sv ====
// L2 TLB testbench
// Directed and random traffic, responses checked by a reference model

`timescale 1ns/1ps

`include "l2_tlb_config.svh"

module tb_l2_tlb import l2_tlb_pkg::*; ();

  localparam int RESET_CYCLES    = 5;
  // Directed tests including drain cycles, counted with margin
  localparam int DIRECTED_CYCLES = 120;
  localparam int RAND_OPS        = 600;
  localparam int MAX_CYCLES      = 4 * (RESET_CYCLES + DIRECTED_CYCLES + RAND_OPS);

  logic clk_i;
  logic rst_ni;
  logic lookup_req_i;
  vpn_t lookup_vpn_i;
  logic refill_i;
  vpn_t refill_vpn_i;
  ppn_t refill_ppn_i;
  logic flush_i;
  logic resp_valid_o;
  logic resp_hit_o;
  ppn_t resp_ppn_o;

  int unsigned lookups_sent = 0;
  int unsigned cycle_count;
  integer      seed;

  l2_tlb i_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lookup_req_i (lookup_req_i),
    .lookup_vpn_i (lookup_vpn_i),
    .refill_i     (refill_i),
    .refill_vpn_i (refill_vpn_i),
    .refill_ppn_i (refill_ppn_i),
    .flush_i      (flush_i),
    .resp_valid_o (resp_valid_o),
    .resp_hit_o   (resp_hit_o),
    .resp_ppn_o   (resp_ppn_o)
  );

  tb_l2_tlb_checker i_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lookup_req_i (lookup_req_i),
    .lookup_vpn_i (lookup_vpn_i),
    .refill_i     (refill_i),
    .refill_vpn_i (refill_vpn_i),
    .refill_ppn_i (refill_ppn_i),
    .flush_i      (flush_i),
    .resp_valid_i (resp_valid_o),
    .resp_hit_i   (resp_hit_o),
    .resp_ppn_i   (resp_ppn_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic vpn_t make_vpn(tag_t tg, set_idx_t idx);
    return {tg, idx};
  endfunction

  // One cycle of strobes, driven at the rising edge
  task automatic apply_strobes(logic lk, vpn_t lvpn, logic rf, vpn_t rvpn, ppn_t rppn,
                               logic fl);
    @(posedge clk_i);
    lookup_req_i <= lk;
    lookup_vpn_i <= lvpn;
    refill_i     <= rf;
    refill_vpn_i <= rvpn;
    refill_ppn_i <= rppn;
    flush_i      <= fl;
    if (lk) begin
      lookups_sent++;
    end
  endtask

  task automatic issue_lookup(vpn_t vpn);
    apply_strobes(1'b1, vpn, 1'b0, '0, '0, 1'b0);
  endtask

  task automatic write_entry(vpn_t vpn, ppn_t ppn);
    apply_strobes(1'b0, '0, 1'b1, vpn, ppn, 1'b0);
  endtask

  task automatic flush_all();
    apply_strobes(1'b0, '0, 1'b0, '0, '0, 1'b1);
  endtask

  task automatic start_test(string name);
    @(negedge clk_i);
    i_checker.begin_test(name);
  endtask

  // Go idle and wait until every lookup has been answered
  task automatic finish_test();
    apply_strobes(1'b0, '0, 1'b0, '0, '0, 1'b0);
    do @(negedge clk_i); while (i_checker.resp_count != lookups_sent);
    i_checker.report_test();
  endtask

  // Run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    logic [31:0] r;
    tag_t        next_tag;
    vpn_t        vpn;
    vpn_t        hist[$];
    int          depth;
    int          pick;
    seed         = 32'h0f3a4175;
    lookup_req_i = 1'b0;
    lookup_vpn_i = '0;
    refill_i     = 1'b0;
    refill_vpn_i = '0;
    refill_ppn_i = '0;
    flush_i      = 1'b0;
    rst_ni       = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    start_test("reset_miss");
    issue_lookup(make_vpn(tag_t'(17'h0), 3'd0));
    issue_lookup(make_vpn(tag_t'(17'h1), 3'd3));
    issue_lookup(make_vpn(tag_t'(17'h1ffff), 3'd7));
    issue_lookup(make_vpn(tag_t'(17'h55), 3'd2));
    finish_test();

    // Same set, other tag must miss
    start_test("refill_hit");
    write_entry(make_vpn(tag_t'(17'h5), 3'd1), 16'h1234);
    issue_lookup(make_vpn(tag_t'(17'h5), 3'd1));
    issue_lookup(make_vpn(tag_t'(17'h6), 3'd1));
    finish_test();

    start_test("fill_set");
    for (int i = 0; i < 4; i++) begin
      write_entry(make_vpn(tag_t'(32'h10 + i), 3'd2), ppn_t'(32'ha000 + i));
    end
    for (int i = 0; i < 4; i++) begin
      issue_lookup(make_vpn(tag_t'(32'h10 + i), 3'd2));
    end
    finish_test();

    // Touch ways 0 and 2, tree then points at way 1
    start_test("plru_victim");
    issue_lookup(make_vpn(tag_t'(17'h10), 3'd2));
    issue_lookup(make_vpn(tag_t'(17'h12), 3'd2));
    write_entry(make_vpn(tag_t'(17'h20), 3'd2), 16'hb020);
    for (int i = 0; i < 4; i++) begin
      issue_lookup(make_vpn(tag_t'(32'h10 + i), 3'd2));
    end
    issue_lookup(make_vpn(tag_t'(17'h20), 3'd2));
    finish_test();

    start_test("flush_refill");
    flush_all();
    issue_lookup(make_vpn(tag_t'(17'h5), 3'd1));
    issue_lookup(make_vpn(tag_t'(17'h10), 3'd2));
    issue_lookup(make_vpn(tag_t'(17'h20), 3'd2));
    write_entry(make_vpn(tag_t'(17'h30), 3'd2), 16'hc030);
    write_entry(make_vpn(tag_t'(17'h31), 3'd2), 16'hc031);
    issue_lookup(make_vpn(tag_t'(17'h30), 3'd2));
    issue_lookup(make_vpn(tag_t'(17'h31), 3'd2));
    finish_test();

    // Back-to-back mix over sets 0 and 1, refill tags never repeat
    start_test("random_mix");
    next_tag = tag_t'(17'h100);
    for (int i = 0; i < RAND_OPS; i++) begin
      r = $random(seed);
      if (r[1:0] == 2'b11 || hist.size() == 0) begin
        vpn = make_vpn(next_tag, {2'b00, r[4]});
        write_entry(vpn, r[31:16]);
        hist.push_back(vpn);
        next_tag++;
      end else if (r[1:0] == 2'b10) begin
        issue_lookup(make_vpn(tag_t'({5'h10, r[19:8]}), {2'b00, r[4]}));
      end else begin
        // Recent refills, most of them still resident
        depth = (hist.size() < 8) ? hist.size() : 8;
        pick  = hist.size() - 1 - (int'(r[10:8]) % depth);
        issue_lookup(hist[pick]);
      end
    end
    finish_test();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             i_checker.tests_run, i_checker.tests_failed, i_checker.check_count,
             i_checker.error_count);
    if (i_checker.error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== dv/tb_l2_tlb_checker.sv ====
// L2 TLB checker
// Reference model of entries and tree bits, compares every lookup response

`timescale 1ns/1ps

`include "l2_tlb_config.svh"

module tb_l2_tlb_checker import l2_tlb_pkg::*; (
  input logic clk_i,
  input logic rst_ni,
  input logic lookup_req_i,
  input vpn_t lookup_vpn_i,
  input logic refill_i,
  input vpn_t refill_vpn_i,
  input ppn_t refill_ppn_i,
  input logic flush_i,
  input logic resp_valid_i,
  input logic resp_hit_i,
  input ppn_t resp_ppn_i
);

  localparam int N_SETS = `L2_TLB_N_SETS;
  localparam int N_WAY  = `L2_TLB_N_WAY;
  localparam int PPN_W  = `L2_TLB_PPN_W;

  // Model of the entry array and the tree bits
  logic       m_valid [N_SETS][N_WAY];
  tag_t       m_tag   [N_SETS][N_WAY];
  ppn_t       m_ppn   [N_SETS][N_WAY];
  logic [2:0] m_tree  [N_SETS];

  // Response owed at the next edge
  logic pend_q;
  logic pend_hit_q;
  ppn_t pend_ppn_q;

  // Counters, read by the testbench top
  int unsigned error_count  = 0;
  int unsigned check_count  = 0;
  int unsigned resp_count   = 0;
  int unsigned tests_run    = 0;
  int unsigned tests_failed = 0;
  int unsigned err_base     = 0;
  int unsigned chk_base     = 0;
  string       cur_test     = "reset";

  // Way that holds the VPN, -1 on a miss
  function automatic int hit_way(vpn_t vpn);
    set_idx_t idx;
    int       way;
    idx = vpn[IDX_W-1:0];
    way = -1;
    for (int w = 0; w < N_WAY; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == vpn[`L2_TLB_VPN_W-1:IDX_W]) begin
        way = w;
      end
    end
    return way;
  endfunction

  // Expected {hit, ppn} of a lookup, ppn zero on a miss
  function automatic logic [PPN_W:0] expected_lookup(vpn_t vpn);
    int way;
    way = hit_way(vpn);
    if (way < 0) begin
      return '0;
    end
    return {1'b1, m_ppn[vpn[IDX_W-1:0]][way]};
  endfunction

  // Victim of a refill, lowest invalid way first, else the tree
  function automatic int victim_way(set_idx_t idx);
    logic [2:0] t;
    t = m_tree[idx];
    for (int w = 0; w < N_WAY; w++) begin
      if (!m_valid[idx][w]) begin
        return w;
      end
    end
    if (!t[0]) begin
      return t[1] ? 1 : 0;
    end
    return t[2] ? 3 : 2;
  endfunction

  // Tree after touching a way, points away from it at both levels
  function automatic logic [2:0] tree_touch(logic [2:0] t, int way);
    logic [2:0] n;
    n = t;
    n[0] = (way < 2);
    if (way < 2) begin
      n[1] = (way == 0);
    end else begin
      n[2] = (way == 2);
    end
    return n;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    int                 way;
    set_idx_t           idx;
    logic [PPN_W:0]     exp;
    if (!rst_ni) begin
      for (int s = 0; s < N_SETS; s++) begin
        m_tree[s] = 3'b000;
        for (int w = 0; w < N_WAY; w++) begin
          m_valid[s][w] = 1'b0;
        end
      end
      pend_q = 1'b0;
    end else begin
      // Compare the response to the lookup sampled one edge earlier
      if (pend_q) begin
        resp_count++;
        check_count++;
        if (!resp_valid_i) begin
          error_count++;
          $display("ERROR %s: no response one cycle after a lookup", cur_test);
        end else if (resp_hit_i !== pend_hit_q || resp_ppn_i !== pend_ppn_q) begin
          error_count++;
          $display("FAILED %s: expected hit=%0b ppn=%h, actual hit=%0b ppn=%h",
                   cur_test, pend_hit_q, pend_ppn_q, resp_hit_i, resp_ppn_i);
        end
      end else if (resp_valid_i) begin
        error_count++;
        $display("ERROR %s: response valid without a lookup", cur_test);
      end
      pend_q = 1'b0;
      // Model update, flush over refill over lookup
      if (flush_i) begin
        for (int s = 0; s < N_SETS; s++) begin
          for (int w = 0; w < N_WAY; w++) begin
            m_valid[s][w] = 1'b0;
          end
        end
      end else if (refill_i) begin
        idx = refill_vpn_i[IDX_W-1:0];
        way = victim_way(idx);
        m_valid[idx][way] = 1'b1;
        m_tag[idx][way]   = refill_vpn_i[`L2_TLB_VPN_W-1:IDX_W];
        m_ppn[idx][way]   = refill_ppn_i;
        m_tree[idx]       = tree_touch(m_tree[idx], way);
      end else if (lookup_req_i) begin
        idx        = lookup_vpn_i[IDX_W-1:0];
        exp        = expected_lookup(lookup_vpn_i);
        pend_q     = 1'b1;
        pend_hit_q = exp[PPN_W];
        pend_ppn_q = exp[PPN_W-1:0];
        way        = hit_way(lookup_vpn_i);
        // Only hits move the tree
        if (way >= 0) begin
          m_tree[idx] = tree_touch(m_tree[idx], way);
        end
      end
    end
  end

  task automatic begin_test(string name);
    cur_test = name;
  endtask

  // One line per finished test
  task automatic report_test();
    int unsigned errs;
    int unsigned chks;
    errs = error_count - err_base;
    chks = check_count - chk_base;
    tests_run++;
    if (errs == 0) begin
      $display("Test %s: pass, %0d checks", cur_test, chks);
    end else begin
      tests_failed++;
      $display("Test %s: fail, %0d errors in %0d checks", cur_test, errs, chks);
    end
    err_base = error_count;
    chk_base = check_count;
  endtask

endmodule

// ==== source/l2_tlb.sv ====
// L2 TLB top level
// 4-way set-associative VPN to PPN translation buffer with pseudo-LRU refill

`timescale 1ns/1ps

`include "l2_tlb_config.svh"

module l2_tlb import l2_tlb_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  // Lookup request
  input  logic lookup_req_i,
  input  vpn_t lookup_vpn_i,
  // Refill request
  input  logic refill_i,
  input  vpn_t refill_vpn_i,
  input  ppn_t refill_ppn_i,
  // Invalidate all entries
  input  logic flush_i,
  // Lookup response
  output logic resp_valid_o,
  output logic resp_hit_o,
  output ppn_t resp_ppn_o
);

  // Address of the current access
  vpn_t     active_vpn;
  set_idx_t index;
  tag_t     tag;

  // Array and replacement unit handshake
  way_vec_t hit_vec;
  way_vec_t valid_vec;
  way_vec_t replace_vec;

  // Refill VPN takes the port when refilling
  assign active_vpn = refill_i ? refill_vpn_i : lookup_vpn_i;

  // Low bits pick the set, the rest is the tag
  assign index = active_vpn[IDX_W-1:0];
  assign tag   = active_vpn[`L2_TLB_VPN_W-1:IDX_W];

  // Translation storage and response
  l2_tlb_entry_array i_entry_array (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_req_i  (lookup_req_i),
    .refill_i      (refill_i),
    .flush_i       (flush_i),
    .index_i       (index),
    .tag_i         (tag),
    .refill_ppn_i  (refill_ppn_i),
    .replace_vec_i (replace_vec),
    .hit_vec_o     (hit_vec),
    .valid_vec_o   (valid_vec),
    .resp_valid_o  (resp_valid_o),
    .resp_hit_o    (resp_hit_o),
    .resp_ppn_o    (resp_ppn_o)
  );

  // Victim selection
  // Lookup hits and refills both refresh the tree
  l2_tlb_replacement_unit i_replacement_unit (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .index_i              (index),
    .hit_vec_i            (hit_vec),
    .valid_vec_i          (valid_vec),
    .valid_tlb_access_i   (lookup_req_i),
    .replacing_an_entry_i (refill_i),
    .replace_vec_o        (replace_vec)
  );

endmodule

// ==== source/l2_tlb_replacement_unit.sv ====
// L2 TLB replacement unit
// Per-set 3-bit tree pseudo-LRU, lowest invalid way is taken first

`timescale 1ns/1ps

`include "l2_tlb_config.svh"

module l2_tlb_replacement_unit import l2_tlb_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Set being accessed
  input  set_idx_t index_i,
  // Status of the indexed set
  input  way_vec_t hit_vec_i,
  input  way_vec_t valid_vec_i,
  // Lookup strobe, tree follows the hit vector
  input  logic     valid_tlb_access_i,
  // Refill strobe, tree follows the replacement vector
  input  logic     replacing_an_entry_i,
  // One-hot victim way
  output way_vec_t replace_vec_o
);

  localparam int unsigned N_SETS = `L2_TLB_N_SETS;
  localparam int unsigned N_WAY  = `L2_TLB_N_WAY;

  // Tree bits per set
  // [0] selects the pair, [1] picks in ways 0/1, [2] picks in ways 2/3
  logic [2:0] plru_q [N_SETS];
  logic [2:0] plru_cur;
  logic [2:0] plru_next;

  // Way touched this cycle, zero when nothing to record
  way_vec_t   access_vec;

  // Candidate victims
  way_vec_t   plru_vec;
  way_vec_t   invalid_first_vec;
  logic       all_valid;

  assign plru_cur = plru_q[index_i];

  // Refill wins over lookup, matching the array
  // A lookup only counts when it hits
  always_comb begin
    access_vec = '0;
    if (replacing_an_entry_i) begin
      access_vec = replace_vec_o;
    end else if (valid_tlb_access_i) begin
      access_vec = hit_vec_i;
    end
  end

  // Next tree state of the indexed set
  // Point away from the touched way at both levels
  always_comb begin
    plru_next = plru_cur;
    if (access_vec[0] || access_vec[1]) begin
      plru_next[0] = 1'b1;
      // Even way points to its odd partner
      plru_next[1] = access_vec[0];
    end else if (access_vec[2] || access_vec[3]) begin
      plru_next[0] = 1'b0;
      plru_next[2] = access_vec[2];
    end
  end

  // Tree flops, updated only for the indexed set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < N_SETS; s++) begin
        plru_q[s] <= '0;
      end
    end else if (|access_vec) begin
      plru_q[index_i] <= plru_next;
    end
  end

  // Decode the tree into a one-hot way
  always_comb begin
    plru_vec = '0;
    if (!plru_cur[0]) begin
      plru_vec[plru_cur[1] ? 1 : 0] = 1'b1;
    end else begin
      plru_vec[plru_cur[2] ? 3 : 2] = 1'b1;
    end
  end

  // Lowest numbered invalid way
  // Scan from the top so the lowest one wins
  always_comb begin
    invalid_first_vec = '0;
    for (int w = N_WAY - 1; w >= 0; w--) begin
      if (!valid_vec_i[w]) begin
        invalid_first_vec    = '0;
        invalid_first_vec[w] = 1'b1;
      end
    end
  end

  assign all_valid = &valid_vec_i;

  // Tree only decides once the set is full
  assign replace_vec_o = all_valid ? plru_vec : invalid_first_vec;

endmodule

// ==== source/l2_tlb_entry_array.sv ====
// L2 TLB entry array
// Valid, tag and PPN storage with tag compare, refill write, flush
// and the registered lookup response

`timescale 1ns/1ps

`include "l2_tlb_config.svh"

module l2_tlb_entry_array import l2_tlb_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Request strobes
  input  logic     lookup_req_i,
  input  logic     refill_i,
  input  logic     flush_i,
  // Indexed set and tag of the active VPN
  input  set_idx_t index_i,
  input  tag_t     tag_i,
  // Translation to write on a refill
  input  ppn_t     refill_ppn_i,
  // One-hot victim way from the replacement unit
  input  way_vec_t replace_vec_i,
  // Per-way status of the indexed set
  output way_vec_t hit_vec_o,
  output way_vec_t valid_vec_o,
  // Registered lookup response
  output logic     resp_valid_o,
  output logic     resp_hit_o,
  output ppn_t     resp_ppn_o
);

  localparam int unsigned N_SETS = `L2_TLB_N_SETS;
  localparam int unsigned N_WAY  = `L2_TLB_N_WAY;

  // Storage
  // Valid bits are control state, tags and PPNs are payload
  way_vec_t valid_q [N_SETS];
  tag_t     tag_q   [N_SETS][N_WAY];
  ppn_t     ppn_q   [N_SETS][N_WAY];

  // Qualified strobes
  logic     refill_we;
  logic     lookup_fire;

  // Compare results of the indexed set
  way_vec_t hit_vec;
  logic     any_hit;
  ppn_t     hit_ppn;

  // Response registers
  logic     resp_valid_q;
  logic     resp_hit_q;
  ppn_t     resp_ppn_q;

  // Flush beats refill, refill beats lookup
  assign refill_we   = refill_i & ~flush_i;
  assign lookup_fire = lookup_req_i & ~refill_i & ~flush_i;

  // Tag compare against all four ways of the indexed set
  always_comb begin
    for (int w = 0; w < N_WAY; w++) begin
      hit_vec[w] = valid_q[index_i][w] && (tag_q[index_i][w] == tag_i);
    end
  end

  assign any_hit = |hit_vec;

  // PPN of the hitting way
  // Only one way hits as long as a VPN is never refilled twice
  always_comb begin
    hit_ppn = '0;
    for (int w = 0; w < N_WAY; w++) begin
      if (hit_vec[w]) begin
        hit_ppn = ppn_q[index_i][w];
      end
    end
  end

  assign hit_vec_o   = hit_vec;
  assign valid_vec_o = valid_q[index_i];

  // Valid bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < N_SETS; s++) begin
        valid_q[s] <= '0;
      end
    end else if (flush_i) begin
      // Flush drops every entry, tree state lives elsewhere and is kept
      for (int s = 0; s < N_SETS; s++) begin
        valid_q[s] <= '0;
      end
    end else if (refill_we) begin
      valid_q[index_i] <= valid_q[index_i] | replace_vec_i;
    end
  end

  // Tag and PPN payload
  // Written into the one-hot victim way only
  always_ff @(posedge clk_i) begin
    if (refill_we) begin
      for (int w = 0; w < N_WAY; w++) begin
        if (replace_vec_i[w]) begin
          tag_q[index_i][w] <= tag_i;
          ppn_q[index_i][w] <= refill_ppn_i;
        end
      end
    end
  end

  // Lookup response, one cycle after the request is sampled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
      resp_hit_q   <= 1'b0;
      resp_ppn_q   <= '0;
    end else begin
      resp_valid_q <= lookup_fire;
      resp_hit_q   <= lookup_fire & any_hit;
      // PPN reads as zero on a miss or when idle
      resp_ppn_q   <= (lookup_fire && any_hit) ? hit_ppn : '0;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_hit_o   = resp_hit_q;
  assign resp_ppn_o   = resp_ppn_q;

endmodule

// ==== source/l2_tlb_pkg.sv ====
// L2 TLB package
// Page number, tag, set index and way vector types

`include "l2_tlb_config.svh"

package l2_tlb_pkg;

  // Set index takes the low VPN bits
  localparam int unsigned IDX_W = $clog2(`L2_TLB_N_SETS);
  // Tag is whatever is left above the index
  localparam int unsigned TAG_W = `L2_TLB_VPN_W - IDX_W;

  // Virtual page number
  typedef logic [`L2_TLB_VPN_W-1:0] vpn_t;

  // Physical page number
  typedef logic [`L2_TLB_PPN_W-1:0] ppn_t;

  // Set index
  typedef logic [IDX_W-1:0] set_idx_t;

  // Tag stored per entry
  typedef logic [TAG_W-1:0] tag_t;

  // One bit per way
  // Hit, valid and replacement vectors
  typedef logic [`L2_TLB_N_WAY-1:0] way_vec_t;

endpackage

// ==== source/l2_tlb_config.svh ====
// L2 TLB configuration
// Geometry and page number widths shared by the package and the RTL

`ifndef L2_TLB_CONFIG_SVH
`define L2_TLB_CONFIG_SVH

// Number of sets, must be a power of two
`define L2_TLB_N_SETS 8

// Virtual page number width in bits
`define L2_TLB_VPN_W 20

// Physical page number width in bits
`define L2_TLB_PPN_W 16

// Associativity
// The pseudo-LRU tree is built for exactly four ways, so this only sizes vectors
`define L2_TLB_N_WAY 4

`endif
